//--- source/tsc_pkg.sv
// Shared definitions for the timestamp-counter peripheral
// Bus, register and compare widths
// Address map of the channel and global register blocks
// TCR field layout and per-channel register write request
// APB phase and register select enums
package tsc_pkg;

   // Bus and register width
   localparam int DATA_W = 32;
   // Compare field in TCR
   localparam int CNT_W = 24;
   // APB address width
   localparam int ADDR_W = 12;

   // Global block base, above all channel blocks
   localparam logic [ADDR_W-1:0] GLB_BASE = 12'h800;
   // Offsets inside a channel block
   localparam logic [3:0] OFS_TSR = 4'h0;
   localparam logic [3:0] OFS_TCR = 4'h4;
   // Offsets inside the global block
   localparam logic [3:0] OFS_IMR = 4'h0;
   localparam logic [3:0] OFS_IVR = 4'h4;

   // Timestamp control register, MSB first
   typedef struct packed {
      logic [3:0]       rsvd;   // Read as zero
      logic             rb1;    // Spare, stored and read back
      logic             p;      // Pending
      logic             i;      // Interrupt enable
      logic             en;     // Count enable
      logic [CNT_W-1:0] cmp;    // Compare value against TSR low bits
   } tcr_t;

   // One register write towards a channel
   typedef struct packed {
      logic              tsr_we;
      logic              tcr_we;
      logic [DATA_W-1:0] data;
   } reg_wr_t;

   // APB bus phase
   typedef enum logic [1:0] {
      IDLE,
      SETUP,
      ACCESS
   } apb_state_e;

   // Decoded register target
   typedef enum logic [2:0] {
      TSR,
      TCR,
      IMR,
      IVR,
      NONE
   } reg_sel_e;

endpackage

//--- source/tsc_counter.sv
// One timestamp channel
// Free-running TSR with software overwrite
// TCR storage with same-cycle write bypass
// Compare match and pending flop
`timescale 1ns/1ns

module tsc_counter import tsc_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  reg_wr_t           wr,
   output logic [DATA_W-1:0] tsr,
   output tcr_t              tcr,
   output logic              pend
);

   tcr_t tcr_q;
   tcr_t tcr_eff;
   logic set_p;
   logic clr_p;

   // TCR storage, p and rsvd are not taken from here on read
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         tcr_q <= '0;
      else if (wr.tcr_we)
         tcr_q <= tcr_t'(wr.data);
   end

   // Readable TCR
   always_comb begin
      tcr      = tcr_q;
      tcr.rsvd = '0;
      // Pending comes from the flop
      tcr.p    = pend;
   end

   // New value acts in its own write cycle
   assign tcr_eff = wr.tcr_we ? tcr_t'(wr.data) : tcr;

   // TSR counter, software write first
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tsr <= '0;
      end else if (wr.tsr_we) begin
         tsr <= wr.data;
      end else if (tcr_eff.en) begin
         tsr <= tsr + 1'b1;
      end
   end

   // Match on low TSR bits with interrupt enabled
   assign set_p = tcr_eff.i && (tsr[CNT_W-1:0] == tcr_eff.cmp);
   // Software clear by writing p low
   assign clr_p = wr.tcr_we && !tcr_eff.p;

   // Pending flop, clear wins
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         pend <= 1'b0;
      else if (clr_p)
         pend <= 1'b0;
      else if (set_p)
         pend <= 1'b1;
   end

   // Pending only rises after a cycle with interrupts on
   a_pend_needs_i: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(pend) |-> $past(tcr_eff.i));

endmodule

//--- source/tsc_irq_ctrl.sv
// Interrupt block of the timestamp-counter peripheral
// Mask register, one registered interrupt line
// Lowest masked pending channel for IVR
`timescale 1ns/1ns

module tsc_irq_ctrl import tsc_pkg::*; #(
   parameter int NUM_TIMERS = 4
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [NUM_TIMERS-1:0] pend,
   input  logic                  imr_we,
   input  logic [NUM_TIMERS-1:0] imr_data,
   output logic [NUM_TIMERS-1:0] imr,
   output logic [DATA_W-1:0]     ivr,
   output logic                  irq
);

   // Channel number width, one bit at least
   localparam int IDX_W = (NUM_TIMERS > 1) ? $clog2(NUM_TIMERS) : 1;

   logic [NUM_TIMERS-1:0] masked;
   logic [IDX_W-1:0]      low_idx;

   // Mask register, set bit enables the channel
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         imr <= '0;
      else if (imr_we)
         imr <= imr_data;
   end

   assign masked = pend & imr;

   // One cycle behind the masked pending bits
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         irq <= 1'b0;
      else
         irq <= |masked;
   end

   // Priority encoder, scan down so the lowest channel wins
   always_comb begin
      low_idx = '0;
      for (int k = NUM_TIMERS - 1; k >= 0; k--) begin
         if (masked[k])
            low_idx = IDX_W'(k);
      end
   end

   // Any-pending flag on top, channel number at the bottom
   always_comb begin
      ivr                = '0;
      ivr[DATA_W-1]      = |masked;
      ivr[IDX_W-1:0]     = low_idx;
   end

   // irq only follows an earlier masked pending bit
   a_irq_cause: assert property (@(posedge clk) disable iff (!rst_n)
      irq |-> $past(|masked));

endmodule

//--- source/tsc_apb_slave.sv
// APB slave of the timestamp-counter peripheral
// Bus phase register and address decode
// Per-channel TSR/TCR write strobes and mask write
// Read data mux and error response
`timescale 1ns/1ns

module tsc_apb_slave import tsc_pkg::*; #(
   parameter int NUM_TIMERS = 4
) (
   input  logic                              clk,
   input  logic                              rst_n,
   // APB
   input  logic [ADDR_W-1:0]                 paddr,
   input  logic                              psel,
   input  logic                              penable,
   input  logic                              pwrite,
   input  logic [DATA_W-1:0]                 pwdata,
   output logic [DATA_W-1:0]                 prdata,
   output logic                              pready,
   output logic                              pslverr,
   // Channel registers
   input  logic [NUM_TIMERS-1:0][DATA_W-1:0] ch_tsr,
   input  tcr_t [NUM_TIMERS-1:0]             ch_tcr,
   output reg_wr_t [NUM_TIMERS-1:0]          ch_wr,
   // Interrupt block
   input  logic [NUM_TIMERS-1:0]             imr,
   input  logic [DATA_W-1:0]                 ivr,
   output logic                              imr_we,
   output logic [NUM_TIMERS-1:0]             imr_data
);

   // Channel index sits between the global bit and the offset
   localparam int IDX_W = ADDR_W - 5;

   apb_state_e              state_q;
   apb_state_e              phase;
   reg_sel_e                sel;
   logic [IDX_W-1:0]        ch_idx;
   logic [3:0]              ofs;
   logic                    access;
   logic                    wr_ok;
   logic [2*NUM_TIMERS:0]   strobes;

   // Phase on the bus this cycle
   always_comb begin
      if (!psel)
         phase = IDLE;
      else if (!penable)
         phase = SETUP;
      else
         phase = ACCESS;
   end

   // Remember last phase so ACCESS is only taken after SETUP
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         state_q <= IDLE;
      else
         state_q <= phase;
   end

   assign access = (phase == ACCESS) && (state_q == SETUP);

   // Address split
   assign ch_idx = paddr[ADDR_W-2:4];
   assign ofs    = paddr[3:0];

   always_comb begin
      sel = NONE;
      if (paddr[ADDR_W-1:4] == GLB_BASE[ADDR_W-1:4]) begin
         // Global block
         if (ofs == OFS_IMR)
            sel = IMR;
         else if (ofs == OFS_IVR)
            sel = IVR;
      end else if (!paddr[ADDR_W-1] && (int'(ch_idx) < NUM_TIMERS)) begin
         // Implemented channel
         if (ofs == OFS_TSR)
            sel = TSR;
         else if (ofs == OFS_TCR)
            sel = TCR;
      end
   end

   // Writes land at the edge closing ACCESS; IVR is read-only
   assign wr_ok = access && pwrite && (sel != NONE);

   always_comb begin
      for (int k = 0; k < NUM_TIMERS; k++) begin
         ch_wr[k].tsr_we = wr_ok && (sel == TSR) && (int'(ch_idx) == k);
         ch_wr[k].tcr_we = wr_ok && (sel == TCR) && (int'(ch_idx) == k);
         ch_wr[k].data   = pwdata;
         strobes[2*k]    = ch_wr[k].tsr_we;
         strobes[2*k+1]  = ch_wr[k].tcr_we;
      end
      strobes[2*NUM_TIMERS] = imr_we;
   end

   assign imr_we   = wr_ok && (sel == IMR);
   assign imr_data = pwdata[NUM_TIMERS-1:0];

   // Read mux, only driven in ACCESS
   always_comb begin
      prdata = '0;
      if (access && !pwrite) begin
         case (sel)
            TSR: begin
               for (int k = 0; k < NUM_TIMERS; k++) begin
                  if (int'(ch_idx) == k)
                     prdata = ch_tsr[k];
               end
            end
            TCR: begin
               for (int k = 0; k < NUM_TIMERS; k++) begin
                  if (int'(ch_idx) == k)
                     prdata = ch_tcr[k];
               end
            end
            IMR:     prdata[NUM_TIMERS-1:0] = imr;
            IVR:     prdata = ivr;
            default: prdata = '0;
         endcase
      end
   end

   // Zero wait states, error for unmapped targets
   assign pready  = 1'b1;
   assign pslverr = access && (sel == NONE);

   // Master never enables without selecting
   a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n)
      penable |-> psel);

   // A transfer touches one register at most
   a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(strobes));

endmodule

//--- source/tsc_top.sv
// Top level of the timestamp-counter peripheral
// APB slave, one counter per channel, interrupt block
`timescale 1ns/1ns

module tsc_top import tsc_pkg::*; #(
   parameter int NUM_TIMERS = 4
) (
   input  logic              clk,
   input  logic              rst_n,
   // APB
   input  logic [ADDR_W-1:0] paddr,
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [DATA_W-1:0] pwdata,
   output logic [DATA_W-1:0] prdata,
   output logic              pready,
   output logic              pslverr,
   // Interrupt
   output logic              irq
);

   reg_wr_t [NUM_TIMERS-1:0]             ch_wr;
   logic [NUM_TIMERS-1:0][DATA_W-1:0]    ch_tsr;
   tcr_t [NUM_TIMERS-1:0]                ch_tcr;
   logic [NUM_TIMERS-1:0]                pend;
   logic                                 imr_we;
   logic [NUM_TIMERS-1:0]                imr_data;
   logic [NUM_TIMERS-1:0]                imr;
   logic [DATA_W-1:0]                    ivr;

   // Bus side
   tsc_apb_slave #(.NUM_TIMERS(NUM_TIMERS)) apb_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .paddr    (paddr),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .pwdata   (pwdata),
      .prdata   (prdata),
      .pready   (pready),
      .pslverr  (pslverr),
      .ch_tsr   (ch_tsr),
      .ch_tcr   (ch_tcr),
      .ch_wr    (ch_wr),
      .imr      (imr),
      .ivr      (ivr),
      .imr_we   (imr_we),
      .imr_data (imr_data)
   );

   // Channels
   for (genvar k = 0; k < NUM_TIMERS; k++) begin : g_ch
      tsc_counter cnt_i (
         .clk   (clk),
         .rst_n (rst_n),
         .wr    (ch_wr[k]),
         .tsr   (ch_tsr[k]),
         .tcr   (ch_tcr[k]),
         .pend  (pend[k])
      );
   end

   // Interrupt combine
   tsc_irq_ctrl #(.NUM_TIMERS(NUM_TIMERS)) irq_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .pend     (pend),
      .imr_we   (imr_we),
      .imr_data (imr_data),
      .imr      (imr),
      .ivr      (ivr),
      .irq      (irq)
   );

endmodule

//--- bench/tsc_tb.sv
// Testbench for the timestamp-counter peripheral
// Clock, reset and APB transfer tasks
// Watchdog sized from the test lengths
// Readback, counting, compare, priority, clear and error tests
`timescale 1ns/1ns

module tsc_tb import tsc_pkg::*; ();

   localparam int NUM_TIMERS = 4;
   localparam int CLK_PERIOD = 4;
   // Compare range for the random test
   localparam int CMP_MIN = 8;
   localparam int CMP_MAX = 40;
   // Transfers per test at two cycles each
   localparam int XFERS = 4 + 5 + 5 + 11 + 4 + 6;
   // Idle waits inside the tests
   localparam int WAITS = (CMP_MAX + 4) + 24 + 2 + 2 + 2;
   // Reset, transfers and waits in cycles
   localparam int RUN_CYC = 6 + 2 * XFERS + WAITS;
   localparam int WATCHDOG_NS = 2 * RUN_CYC * CLK_PERIOD;
   // Global block
   localparam logic [ADDR_W-1:0] IMR_ADDR = 12'h800;
   localparam logic [ADDR_W-1:0] IVR_ADDR = 12'h804;

   logic              clk;
   logic              rst_n;
   logic [ADDR_W-1:0] paddr;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [DATA_W-1:0] pwdata;
   logic [DATA_W-1:0] prdata;
   logic              pready;
   logic              pslverr;
   logic              irq;

   string  test_name;
   int     errors;
   int     errs_before;
   int     tests_passed;
   int     tests_failed;
   integer seed;

   tsc_top #(.NUM_TIMERS(NUM_TIMERS)) dut_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .paddr   (paddr),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .irq     (irq)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Ends a run that stalls
   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired, run did not finish within %0d ns", WATCHDOG_NS);
      $display("SOME TESTS FAILED");
      $finish;
   end

   // Address of a register inside channel ch
   function automatic logic [ADDR_W-1:0] ch_addr(input int ch, input int ofs);
      return ADDR_W'(ch * 16 + ofs);
   endfunction

   task automatic check_eq(input string what, input logic [DATA_W-1:0] exp,
                           input logic [DATA_W-1:0] act);
      assert (act === exp)
      else begin
         $display("ERROR %s %s: expected 0x%08h, actual 0x%08h",
                  test_name, what, exp, act);
         errors++;
      end
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      errs_before = errors;
   endtask

   task automatic end_test();
      if (errors == errs_before) begin
         tests_passed++;
         $display("test %s: passed", test_name);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d errors", test_name, errors - errs_before);
      end
   endtask

   // Starts on a falling edge and ends on the falling edge after ACCESS
   task automatic apb_transfer(input logic wr, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] wdata,
                               output logic [DATA_W-1:0] rdata, output logic err);
      paddr   = addr;
      pwrite  = wr;
      pwdata  = wdata;
      psel    = 1'b1;
      penable = 1'b0;
      @(negedge clk);
      penable = 1'b1;
      // Response settles well before the closing edge
      #1;
      rdata = prdata;
      err   = pslverr;
      // Zero wait states on every transfer
      check_eq("pready", 1, 32'(pready));
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            output logic err);
      logic [DATA_W-1:0] unused;
      apb_transfer(1'b1, addr, data, unused, err);
   endtask

   task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                           output logic err);
      apb_transfer(1'b0, addr, '0, data, err);
   endtask

   initial begin
      logic [DATA_W-1:0] rd;
      logic [DATA_W-1:0] rd2;
      logic              err;
      tcr_t              tcr_w;
      tcr_t              tcr_exp;
      tcr_t              tcr_ch2;
      tcr_t              tcr_rd;
      int                cmp_val;

      rst_n        = 1'b0;
      paddr        = '0;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      pwdata       = '0;
      errors       = 0;
      tests_passed = 0;
      tests_failed = 0;
      seed         = 89;
      repeat (5) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);

      // Channel 2 stays stopped so values read back as written
      start_test("readback");
      apb_write(ch_addr(2, 0), 32'hDEAD_BEEF, err);
      check_eq("TSR write pslverr", 0, 32'(err));
      tcr_w      = '0;
      tcr_w.rsvd = 4'hA;
      tcr_w.rb1  = 1'b1;
      tcr_w.p    = 1'b1;
      tcr_w.cmp  = 24'h12_3456;
      apb_write(ch_addr(2, 4), tcr_w, err);
      apb_read(ch_addr(2, 0), rd, err);
      check_eq("TSR", 32'hDEAD_BEEF, rd);
      check_eq("TSR read pslverr", 0, 32'(err));
      tcr_ch2      = tcr_w;
      tcr_ch2.rsvd = '0;
      tcr_ch2.p    = 1'b0;
      apb_read(ch_addr(2, 4), rd, err);
      check_eq("TCR", tcr_ch2, rd);
      end_test();

      // Channel 0 counts every clock
      start_test("counting");
      tcr_w    = '0;
      tcr_w.en = 1'b1;
      apb_write(ch_addr(0, 4), tcr_w, err);
      apb_read(ch_addr(0, 0), rd, err);
      apb_read(ch_addr(0, 0), rd2, err);
      check_eq("TSR step per transfer", 32'd2, rd2 - rd);
      apb_write(ch_addr(0, 0), 32'h1000_0000, err);
      apb_read(ch_addr(0, 0), rd, err);
      // One counting edge between write and read
      check_eq("TSR after restart", 32'h1000_0001, rd);
      end_test();

      // Channel 1 matches a random compare value
      start_test("compare");
      cmp_val = CMP_MIN + int'($unsigned($random(seed)) % (CMP_MAX - CMP_MIN + 1));
      apb_write(IMR_ADDR, 32'h2, err);
      apb_write(ch_addr(1, 0), 32'h0, err);
      tcr_w     = '0;
      tcr_w.i   = 1'b1;
      tcr_w.en  = 1'b1;
      tcr_w.cmp = CNT_W'(cmp_val);
      apb_write(ch_addr(1, 4), tcr_w, err);
      repeat (cmp_val + 4) @(negedge clk);
      check_eq("irq after match", 1, 32'(irq));
      tcr_exp   = tcr_w;
      tcr_exp.p = 1'b1;
      apb_read(ch_addr(1, 4), rd, err);
      check_eq("TCR pending", tcr_exp, rd);
      apb_read(IVR_ADDR, rd, err);
      check_eq("IVR", 32'h8000_0001, rd);
      end_test();

      // Channels 0 and 3 both pending
      start_test("priority_mask");
      apb_write(ch_addr(0, 0), 32'h0, err);
      tcr_w     = '0;
      tcr_w.i   = 1'b1;
      tcr_w.en  = 1'b1;
      tcr_w.cmp = 24'd10;
      apb_write(ch_addr(0, 4), tcr_w, err);
      apb_write(ch_addr(3, 0), 32'h0, err);
      tcr_w.cmp = 24'd6;
      apb_write(ch_addr(3, 4), tcr_w, err);
      apb_write(IMR_ADDR, 32'h9, err);
      repeat (24) @(negedge clk);
      apb_read(IVR_ADDR, rd, err);
      check_eq("IVR lowest channel", 32'h8000_0000, rd);
      apb_write(IMR_ADDR, 32'h8, err);
      apb_read(IVR_ADDR, rd, err);
      check_eq("IVR with channel 0 masked", 32'h8000_0003, rd);
      apb_write(IMR_ADDR, 32'h0, err);
      repeat (2) @(negedge clk);
      check_eq("irq with all masked", 0, 32'(irq));
      apb_read(ch_addr(0, 4), rd, err);
      tcr_rd = tcr_t'(rd);
      check_eq("channel 0 p", 1, 32'(tcr_rd.p));
      apb_read(ch_addr(3, 4), rd, err);
      tcr_rd = tcr_t'(rd);
      check_eq("channel 3 p", 1, 32'(tcr_rd.p));
      end_test();

      // Software clear on channel 1
      start_test("clear");
      apb_write(IMR_ADDR, 32'h2, err);
      repeat (2) @(negedge clk);
      check_eq("irq before clear", 1, 32'(irq));
      tcr_w     = '0;
      tcr_w.en  = 1'b1;
      tcr_w.cmp = CNT_W'(cmp_val);
      apb_write(ch_addr(1, 4), tcr_w, err);
      repeat (2) @(negedge clk);
      check_eq("irq after clear", 0, 32'(irq));
      apb_read(ch_addr(1, 4), rd, err);
      check_eq("TCR after clear", tcr_w, rd);
      apb_read(IVR_ADDR, rd, err);
      check_eq("IVR after clear", 32'h0, rd);
      end_test();

      // Unmapped channel and global offset
      start_test("errors");
      apb_write(12'h054, 32'hFFFF_FFFF, err);
      check_eq("pslverr write channel 5", 1, 32'(err));
      apb_read(12'h054, rd, err);
      check_eq("pslverr read channel 5", 1, 32'(err));
      apb_write(12'h808, 32'hFFFF_FFFF, err);
      check_eq("pslverr write global 0x8", 1, 32'(err));
      apb_read(12'h808, rd, err);
      check_eq("pslverr read global 0x8", 1, 32'(err));
      // Channel 5 with the top index bit lost would land on channel 1
      apb_read(ch_addr(1, 4), rd, err);
      check_eq("channel 1 TCR kept", tcr_w, rd);
      apb_read(IMR_ADDR, rd, err);
      check_eq("IMR kept", 32'h2, rd);
      end_test();

      $display("tests passed %0d, failed %0d, check errors %0d",
               tests_passed, tests_failed, errors);
      if (tests_failed == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- sources.f
source/tsc_pkg.sv
source/tsc_counter.sv
source/tsc_irq_ctrl.sv
source/tsc_apb_slave.sv
source/tsc_top.sv
bench/tsc_tb.sv

//--- Makefile
# Verilator build and run of the timestamp-counter testbench

SIM  := obj_dir/Vtsc_tb
SRCS := $(shell cat sources.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): sources.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tsc_tb -f sources.f -o Vtsc_tb

# Fails on a nonzero exit or on the fail message in the log
run: $(SIM)
	./$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "SOME TESTS FAILED" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
